/* design/crc_a_pkg.sv */
// CRC_A constants per ISO/IEC 14443-3; bits are processed least significant first, so the polynomial is reflected
`default_nettype none

package crc_a_pkg;

    // width of the CRC_A register and of every CRC word in the subsystem
    localparam int CRC_W = 16;

    // a CRC value as held by the engine and seen by the framer
    typedef logic [CRC_W-1:0] crc_t;

    // register value loaded at the start of every frame
    // ISO 14443-3 defines this as 0x6363 for type A cards
    localparam crc_t CRC_A_PRESET = 16'h6363;

    // x^16 + x^12 + x^5 + 1 written in bit-reversed order
    // the normal form would be 0x1021, but the data arrives lsb first
    // so the register shifts right and uses the mirrored taps
    localparam crc_t CRC_A_POLY_REFL = 16'h8408;

    // which bit stream the shared engine is currently following
    // rx is the idle choice since the card mostly listens
    typedef enum logic {
        CRC_MODE_RX = 1'b0,
        CRC_MODE_TX = 1'b1
    } crc_mode_t;

    // a received frame including its two crc bytes leaves the
    // register at zero when nothing was corrupted on the way
    // the residue check lives in crc_control

    // the tx side appends the register value low byte first,
    // bit 0 going out first, which matches the rx residue rule

endpackage

`default_nettype wire

/* design/crc_a.sv */
// one bit per sample strobe; start and sample must never be high together, and the preset is fixed by the standard
`default_nettype none
`timescale 1ns/1ns

module crc_a (
    input  wire             clk,
    input  wire             rst_n,
    // loads the preset for a new frame
    input  wire logic       start,
    // shifts data into the register
    input  wire logic       sample,
    input  wire logic       data,
    output crc_a_pkg::crc_t crc
);

    import crc_a_pkg::*;

    logic feedback;
    crc_t crc_next;

    // the incoming bit is combined with the bit about to leave the register
    assign feedback = crc[0] ^ data;

    // reflected lfsr step, shift right and fold in the taps when the feedback is set
    assign crc_next = (crc >> 1) ^ (feedback ? CRC_A_POLY_REFL : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // reset leaves the register as if a frame had just started
            crc <= CRC_A_PRESET;
        end else if (start) begin
            crc <= CRC_A_PRESET;
        end else if (sample) begin
            crc <= crc_next;
        end
    end

    // a start together with a sample would drop a bit at the head of a frame
    // the controller's spacing of its strobes is meant to prevent this
    a_start_sample_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(start && sample)
    ) else $error("crc_a start and sample high in the same cycle");

endmodule

`default_nettype wire

/* design/crc_control.sv */
// rx and tx never run at once; a new rx start of frame always takes the engine, even in the middle of a tx frame
`default_nettype none
`timescale 1ns/1ns

module crc_control (
    input  wire                clk,
    input  wire                rst_n,
    // decoded rx bits, lsb first, with a start-of-frame strobe
    input  wire logic          rx_soc,
    input  wire logic          rx_bit,
    input  wire logic          rx_bit_valid,
    // tx framer events
    input  wire logic          tx_crc_start,
    input  wire logic          tx_data_bit,
    input  wire logic          tx_bit,
    output logic               rx_crc_ok,
    output crc_a_pkg::crc_mode_t crc_mode,
    output crc_a_pkg::crc_t    crc
);

    import crc_a_pkg::*;

    logic crc_start;
    logic crc_sample;
    logic crc_data;

    crc_a u_crc_a (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (crc_start),
        .sample (crc_sample),
        .data   (crc_data),
        .crc    (crc)
    );

    // the residue of a good frame, crc bytes included, is zero
    assign rx_crc_ok = (crc == '0);

    // mode and strobe generation, every strobe lags its cause by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_mode   <= CRC_MODE_RX;
            crc_start  <= 1'b0;
            crc_sample <= 1'b0;
        end else begin
            // rx start of frame has priority over a framer start
            crc_start <= rx_soc | tx_crc_start;
            if (rx_soc) begin
                crc_mode <= CRC_MODE_RX;
            end else if (tx_crc_start) begin
                crc_mode <= CRC_MODE_TX;
            end
            // only the stream of the current mode feeds the engine
            if (crc_mode == CRC_MODE_RX) begin
                crc_sample <= rx_bit_valid;
            end else begin
                crc_sample <= tx_data_bit;
            end
        end
    end

    // the sampled bit itself, only meaningful alongside crc_sample
    always_ff @(posedge clk) begin
        if (crc_mode == CRC_MODE_RX) begin
            if (rx_bit_valid) crc_data <= rx_bit;
        end else begin
            if (tx_data_bit) crc_data <= tx_bit;
        end
    end

    // both strobes rely on the rx spacing rule and the framer's one-shot start
    a_start_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        crc_start |=> !crc_start
    ) else $error("crc_start held for more than one cycle");

    a_sample_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        crc_sample |=> !crc_sample
    ) else $error("crc_sample held for more than one cycle");

endmodule

`default_nettype wire

/* design/tx_framer.sv */
// bit requests must be at least 3 cycles apart; no frame is sent before fdt_trigger and no abort exists
`default_nettype none
`timescale 1ns/1ns

module tx_framer (
    input  wire             clk,
    input  wire             rst_n,
    // four-phase byte source
    input  wire logic       tx_byte_req,
    input  wire logic       tx_byte_last,
    input  wire logic [7:0] tx_byte,
    output logic            tx_byte_ack,
    input  wire logic       tx_append_crc,
    input  wire logic       fdt_trigger,
    // modulator side
    input  wire logic       tx_bit_req,
    input  wire crc_a_pkg::crc_t crc,
    output logic            tx_bit,
    output logic            tx_bit_valid,
    output logic            tx_done,
    output logic            tx_crc_start,
    output logic            tx_data_bit
);

    import crc_a_pkg::*;

    localparam int IDX_W = $clog2(CRC_W);

    typedef enum logic [1:0] {
        ST_IDLE, ST_WAIT, ST_DATA, ST_CRC
    } state_t;

    state_t           state;
    logic [7:0]       byte_reg;
    logic             byte_last_reg;
    logic             byte_full;
    logic [7:0]       shift_reg;
    logic [2:0]       bit_cnt;
    logic             cur_last;
    logic             append_reg;
    logic             fdt_seen;
    logic [IDX_W-1:0] crc_idx;
    logic             accept, launch, consume, refill, load, frame_tail;

    // once the last byte is shifting, the next byte belongs to a new frame
    assign frame_tail = ((state == ST_DATA) || (state == ST_CRC)) && cur_last;
    assign accept     = tx_byte_req && !tx_byte_ack && !byte_full && !frame_tail;
    assign launch     = (state == ST_WAIT) && (fdt_trigger || fdt_seen);
    assign consume    = tx_bit_req && tx_bit_valid;
    // next byte either follows the last bit directly or ends a starved wait
    assign refill     = (state == ST_DATA) && byte_full && !cur_last &&
                        (!tx_bit_valid || (consume && (bit_cnt == 3'd7)));
    assign load       = launch || refill;

    assign tx_crc_start = launch && append_reg;
    assign tx_data_bit  = consume && (state == ST_DATA);
    // crc bits come straight from the engine, which is final by then
    assign tx_bit       = (state == ST_CRC) ? crc[crc_idx] : shift_reg[0];

    always_ff @(posedge clk) begin
        if (accept) begin
            byte_reg      <= tx_byte;
            byte_last_reg <= tx_byte_last;
        end
        if (load) begin
            shift_reg <= byte_reg;
        end else if (tx_data_bit) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            byte_full    <= 1'b0;
            tx_byte_ack  <= 1'b0;
            append_reg   <= 1'b0;
            fdt_seen     <= 1'b0;
            bit_cnt      <= '0;
            cur_last     <= 1'b0;
            crc_idx      <= '0;
            tx_bit_valid <= 1'b0;
            tx_done      <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            // ack rises with the latch and falls after the source drops req
            if (accept) begin
                tx_byte_ack <= 1'b1;
                byte_full   <= 1'b1;
            end else if (tx_byte_ack && !tx_byte_req) begin
                tx_byte_ack <= 1'b0;
            end
            // a trigger may arrive before the first byte
            if (fdt_trigger && ((state == ST_IDLE) || (state == ST_WAIT))) fdt_seen <= 1'b1;
            if (launch) fdt_seen <= 1'b0;
            if (load) begin
                byte_full    <= 1'b0;
                bit_cnt      <= '0;
                cur_last     <= byte_last_reg;
                tx_bit_valid <= 1'b1;
            end
            case (state)
                ST_IDLE: if (accept) begin
                    state      <= ST_WAIT;
                    append_reg <= tx_append_crc;
                end
                ST_WAIT: if (launch) state <= ST_DATA;
                ST_DATA: if (consume) begin
                    if (bit_cnt != 3'd7) begin
                        bit_cnt <= bit_cnt + 3'd1;
                    end else if (cur_last && append_reg) begin
                        state   <= ST_CRC;
                        crc_idx <= '0;
                    end else if (cur_last) begin
                        state        <= ST_IDLE;
                        tx_bit_valid <= 1'b0;
                        tx_done      <= 1'b1;
                    end else if (!byte_full) begin
                        // starved, hold in data until the source catches up
                        tx_bit_valid <= 1'b0;
                    end
                end
                ST_CRC: if (consume) begin
                    if (crc_idx == IDX_W'(CRC_W - 1)) begin
                        state        <= ST_IDLE;
                        tx_bit_valid <= 1'b0;
                        tx_done      <= 1'b1;
                    end else begin
                        crc_idx <= crc_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the crc needs two cycles after the last data bit before it can be shown
    a_req_spacing : assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_bit_req |=> !tx_bit_req [*2]
    ) else $error("tx_bit_req closer than 3 cycles");

    a_byte_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_byte_req && !tx_byte_ack) |=> $stable(tx_byte)
    ) else $error("tx_byte changed before it was acknowledged");

endmodule

`default_nettype wire

/* design/crc_a_subsystem.sv */
// single shared crc engine, so an rx frame arriving during tx corrupts the tx crc; clk is free running
`default_nettype none
`timescale 1ns/1ns

module crc_a_subsystem (
    input  wire                  clk,
    input  wire                  rst_n,
    // rx bit stream, already decoded
    input  wire logic            rx_soc,
    input  wire logic            rx_bit,
    input  wire logic            rx_bit_valid,
    // tx byte source, four-phase req/ack
    input  wire logic            tx_byte_req,
    input  wire logic [7:0]      tx_byte,
    input  wire logic            tx_byte_last,
    output logic                 tx_byte_ack,
    // per-frame tx controls
    input  wire logic            tx_append_crc,
    input  wire logic            fdt_trigger,
    // modulator handshake
    input  wire logic            tx_bit_req,
    output logic                 tx_bit,
    output logic                 tx_bit_valid,
    output logic                 tx_done,
    // crc status
    output logic                 rx_crc_ok,
    output crc_a_pkg::crc_mode_t crc_mode,
    output crc_a_pkg::crc_t      crc
);

    // framer events that steer the engine onto the tx stream
    logic tx_crc_start;
    logic tx_data_bit;

    tx_framer u_tx_framer (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_byte_req   (tx_byte_req),
        .tx_byte_last  (tx_byte_last),
        .tx_byte       (tx_byte),
        .tx_byte_ack   (tx_byte_ack),
        .tx_append_crc (tx_append_crc),
        .fdt_trigger   (fdt_trigger),
        .tx_bit_req    (tx_bit_req),
        .crc           (crc),
        .tx_bit        (tx_bit),
        .tx_bit_valid  (tx_bit_valid),
        .tx_done       (tx_done),
        .tx_crc_start  (tx_crc_start),
        .tx_data_bit   (tx_data_bit)
    );

    // the engine sits in here and its value is shared with the framer
    crc_control u_crc_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_soc       (rx_soc),
        .rx_bit       (rx_bit),
        .rx_bit_valid (rx_bit_valid),
        .tx_crc_start (tx_crc_start),
        .tx_data_bit  (tx_data_bit),
        .tx_bit       (tx_bit),
        .rx_crc_ok    (rx_crc_ok),
        .crc_mode     (crc_mode),
        .crc          (crc)
    );

endmodule

`default_nettype wire

/* testbench/tb_crc_a_subsystem.sv */
// rx and tx are exercised one after the other, never together; every wait is bounded by TIMEOUT cycles
`default_nettype none
`timescale 1ns/1ns

module tb_crc_a_subsystem;

    import crc_a_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    localparam int TIMEOUT = 4000;

    logic       clk;
    logic       rst_n;
    logic       rx_soc;
    logic       rx_bit;
    logic       rx_bit_valid;
    logic       tx_byte_req;
    logic [7:0] tx_byte;
    logic       tx_byte_last;
    logic       tx_append_crc;
    logic       fdt_trigger;
    logic       tx_bit_req;
    logic       tx_byte_ack;
    logic       tx_bit;
    logic       tx_bit_valid;
    logic       tx_done;
    logic       rx_crc_ok;
    crc_mode_t  crc_mode;
    crc_t       crc;

    int   seed = 45;
    int   errors = 0;
    int   done_cnt = 0;
    int   valid_falls = 0;
    logic prev_valid = 1'b0;
    logic fdt_fired = 1'b0;
    // bits taken by the modulator model, in the order they were consumed
    logic tx_bits[$];

    crc_a_subsystem dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_soc        (rx_soc),
        .rx_bit        (rx_bit),
        .rx_bit_valid  (rx_bit_valid),
        .tx_byte_req   (tx_byte_req),
        .tx_byte       (tx_byte),
        .tx_byte_last  (tx_byte_last),
        .tx_byte_ack   (tx_byte_ack),
        .tx_append_crc (tx_append_crc),
        .fdt_trigger   (fdt_trigger),
        .tx_bit_req    (tx_bit_req),
        .tx_bit        (tx_bit),
        .tx_bit_valid  (tx_bit_valid),
        .tx_done       (tx_done),
        .rx_crc_ok     (rx_crc_ok),
        .crc_mode      (crc_mode),
        .crc           (crc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic byte_q_t random_bytes(input int lo, input int hi);
        byte_q_t q;
        int      i;
        int      n;
        n = rand_range(lo, hi);
        for (i = 0; i < n; i++) begin
            q.push_back(8'($random(seed)));
        end
        return q;
    endfunction

    // CRC_A of a byte queue, every byte taken lsb first through the reflected register
    function automatic crc_t crc_a_ref(input byte_q_t data);
        crc_t c;
        logic fb;
        int   b;
        c = CRC_A_PRESET;
        foreach (data[i]) begin
            for (b = 0; b < 8; b++) begin
                fb = c[0] ^ data[i][b];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ CRC_A_POLY_REFL;
                end
            end
        end
        return c;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_crc(input string name, input crc_t exp, input crc_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_mode(input string name, input crc_mode_t exp, input crc_mode_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (tx_byte_ack !== level && n < TIMEOUT);
        if (tx_byte_ack !== level) begin
            errors++;
            $display("timeout while waiting for tx_byte_ack to become %b", level);
        end
    endtask

    task automatic wait_tx_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (tx_done !== 1'b1 && n < TIMEOUT);
        if (tx_done !== 1'b1) begin
            errors++;
            $display("timeout while waiting for tx_done");
        end
    endtask

    task automatic pulse_fdt();
        @(posedge clk);
        fdt_trigger <= 1'b1;
        fdt_fired = 1'b1;
        @(posedge clk);
        fdt_trigger <= 1'b0;
    endtask

    // four-phase source, a random pause before every req
    task automatic send_bytes(input byte_q_t data, input logic append, input int lo, input int hi);
        int i;
        for (i = 0; i < data.size(); i++) begin
            repeat (rand_range(lo, hi)) @(posedge clk);
            @(posedge clk);
            tx_byte_req   <= 1'b1;
            tx_byte       <= data[i];
            tx_byte_last  <= (i == data.size() - 1);
            tx_append_crc <= append;
            wait_ack(1'b1);
            @(posedge clk);
            tx_byte_req <= 1'b0;
            wait_ack(1'b0);
        end
    endtask

    // valid strobes are at least 3 cycles apart and 2 cycles after the start of frame
    task automatic send_rx_frame(input byte_q_t data, input int flip);
        int i;
        int b;
        int k;
        @(posedge clk);
        rx_soc <= 1'b1;
        @(posedge clk);
        rx_soc <= 1'b0;
        k = 0;
        for (i = 0; i < data.size(); i++) begin
            for (b = 0; b < 8; b++) begin
                repeat (rand_range(2, 4)) @(posedge clk);
                rx_bit       <= data[i][b] ^ (k == flip);
                rx_bit_valid <= 1'b1;
                @(posedge clk);
                rx_bit_valid <= 1'b0;
                k++;
            end
        end
    endtask

    task automatic run_rx(input string name, input logic corrupt);
        byte_q_t frame;
        crc_t    c;
        int      flip;
        frame = random_bytes(1, 6);
        c = crc_a_ref(frame);
        // the crc travels low byte first behind the data
        frame.push_back(c[7:0]);
        frame.push_back(c[15:8]);
        flip = corrupt ? rand_range(0, frame.size() * 8 - 1) : -1;
        send_rx_frame(frame, flip);
        // the residue is in the register two cycles after the last strobe
        @(posedge clk);
        @(negedge clk);
        check_bit({name, "_ok"}, !corrupt, rx_crc_ok);
        check_mode({name, "_mode"}, CRC_MODE_RX, crc_mode);
        if (!corrupt) begin
            check_crc({name, "_residue"}, '0, crc);
        end
    endtask

    // late bytes arrive after the framer has drained the previous byte, so it starves
    task automatic run_tx(input string name, input logic append, input logic late);
        byte_q_t data;
        logic    exp_bits[$];
        crc_t    ref_crc;
        int      i;
        int      b;
        int      n;
        if (late) begin
            data = random_bytes(2, 5);
        end else begin
            data = random_bytes(1, 6);
        end
        tx_bits.delete();
        done_cnt    = 0;
        valid_falls = 0;
        fdt_fired   = 1'b0;
        if (late) begin
            pulse_fdt();
        end
        fork
            send_bytes(data, append, late ? 80 : 0, late ? 110 : 3);
            if (!late) begin
                wait_ack(1'b1);
                // a loaded frame has to sit still until the trigger
                repeat (rand_range(4, 12)) @(posedge clk);
                pulse_fdt();
            end
        join
        wait_tx_done();
        repeat (20) @(negedge clk);
        for (i = 0; i < data.size(); i++) begin
            for (b = 0; b < 8; b++) begin
                exp_bits.push_back(data[i][b]);
            end
        end
        ref_crc = crc_a_ref(data);
        if (append) begin
            for (b = 0; b < CRC_W; b++) begin
                exp_bits.push_back(ref_crc[b]);
            end
        end
        // a lost or repeated bit shows up as x on one side
        n = (exp_bits.size() > tx_bits.size()) ? exp_bits.size() : tx_bits.size();
        for (i = 0; i < n; i++) begin
            check_bit($sformatf("%s_bit%0d", name, i),
                      (i < exp_bits.size()) ? exp_bits[i] : 1'bx,
                      (i < tx_bits.size()) ? tx_bits[i] : 1'bx);
        end
        check_bit({name, "_done_once"}, 1'b1, done_cnt == 1);
        if (append) begin
            check_crc({name, "_crc"}, ref_crc, crc);
            check_mode({name, "_mode"}, CRC_MODE_TX, crc_mode);
        end else begin
            check_mode({name, "_mode"}, CRC_MODE_RX, crc_mode);
        end
        if (late) begin
            check_bit({name, "_valid_drop"}, 1'b1, valid_falls > 1);
        end
    endtask

    // modulator model with 3 to 7 cycles from one request to the next
    initial begin : modulator
        int gap;
        forever begin
            @(negedge clk);
            if (rst_n && tx_bit_valid) begin
                @(posedge clk);
                tx_bit_req <= 1'b1;
                @(negedge clk);
                tx_bits.push_back(tx_bit);
                @(posedge clk);
                tx_bit_req <= 1'b0;
                gap = rand_range(3, 7);
                repeat (gap - 2) @(posedge clk);
            end
        end
    end

    // done pulses and falls of tx_bit_valid are counted per frame
    always @(negedge clk) begin
        if (rst_n) begin
            if (tx_done) done_cnt++;
            if (prev_valid && !tx_bit_valid) valid_falls++;
            if (tx_bit_valid && !fdt_fired) begin
                errors++;
                $display("tx_bit_valid went high before fdt_trigger was given");
            end
        end
        prev_valid = tx_bit_valid;
    end

    initial begin : stimulus
        int t;
        rst_n         <= 1'b0;
        rx_soc        <= 1'b0;
        rx_bit        <= 1'b0;
        rx_bit_valid  <= 1'b0;
        tx_byte_req   <= 1'b0;
        tx_byte       <= 8'h00;
        tx_byte_last  <= 1'b0;
        tx_append_crc <= 1'b0;
        fdt_trigger   <= 1'b0;
        tx_bit_req    <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("reset_ack", 1'b0, tx_byte_ack);
        check_bit("reset_valid", 1'b0, tx_bit_valid);
        check_bit("reset_done", 1'b0, tx_done);
        check_mode("reset_mode", CRC_MODE_RX, crc_mode);
        check_crc("reset_crc", CRC_A_PRESET, crc);
        for (t = 0; t < 4; t++) run_rx($sformatf("rx_good%0d", t), 1'b0);
        for (t = 0; t < 4; t++) run_rx($sformatf("rx_bad%0d", t), 1'b1);
        // mode is still rx here, which the no-crc frames must leave alone
        for (t = 0; t < 2; t++) run_tx($sformatf("tx_plain%0d", t), 1'b0, 1'b0);
        for (t = 0; t < 3; t++) run_tx($sformatf("tx_crc%0d", t), 1'b1, 1'b0);
        for (t = 0; t < 2; t++) run_tx($sformatf("tx_late%0d", t), 1'b1, 1'b1);
        // the engine is left in tx mode, so an rx start of frame has to take it back
        for (t = 0; t < 2; t++) run_rx($sformatf("rx_after_tx%0d", t), 1'b0);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/crc_a_pkg.sv
design/crc_a.sv
design/crc_control.sv
design/tx_framer.sv
design/crc_a_subsystem.sv
testbench/tb_crc_a_subsystem.sv

/* Bender.yml */
package:
  name: crc_a_subsystem

sources:
  - target: rtl
    files:
      - design/crc_a_pkg.sv
      - design/crc_a.sv
      - design/crc_control.sv
      - design/tx_framer.sv
      - design/crc_a_subsystem.sv
  - target: test
    files:
      - testbench/tb_crc_a_subsystem.sv
